// ==== hw/s2mm_pkg.sv ====
package s2mm_pkg;

	typedef logic [31:0] addr_t;     // byte address
	typedef logic [23:0] btt_t;      // bytes to transfer per command
	typedef logic [23:0] beat_cnt_t; // beats left in a command
	typedef logic [7:0]  axi_len_t;  // burst length minus one

	typedef struct packed {
		addr_t addr;
		btt_t  btt;
	} cmd_t;

	// one INCR burst as cut by the splitter
	typedef struct packed {
		addr_t    addr;
		axi_len_t len;
		logic     last_of_cmd; // final burst of its command
	} burst_desc_t;

	typedef enum logic [1:0] {IDLE, GEN_LEN, CLIP_4K, LAUNCH} split_state_e;

	// lifecycle of a burst table entry
	typedef enum logic [1:0] {FREE, PRE_LAUNCHED, DATA_READY, IN_TRANSFER} entry_state_e;

	localparam int TABLE_DEPTH    = 4;
	localparam int BOUNDARY_BYTES = 4096;

	localparam logic [1:0] AXI_BURST_INCR    = 2'b01;
	localparam logic [3:0] AXI_CACHE_DEFAULT = 4'b0011; // bufferable, modifiable
	localparam logic [2:0] AXI_PROT_DEFAULT  = 3'b000;

endpackage

// ==== hw/s2mm_burst_splitter.sv ====
module s2mm_burst_splitter #(
	parameter int DATA_WIDTH    = 32,
	parameter int MAX_BURST_LEN = 16
) (
	input  logic                  m_axi_aclk,
	input  logic                  m_axi_aresetn,
	input  s2mm_pkg::cmd_t        cmd_i,
	input  logic                  cmd_valid_i,
	output logic                  cmd_ready_o,
	output s2mm_pkg::burst_desc_t desc_o,
	output logic                  launch_valid_o,
	input  logic                  launch_ready_i
);

	localparam int BYTES = DATA_WIDTH / 8;
	localparam int OFS_W = $clog2(BYTES);
	localparam int B4K_W = $clog2(s2mm_pkg::BOUNDARY_BYTES / BYTES);
	localparam s2mm_pkg::beat_cnt_t MAX_LEN_SUB1 = s2mm_pkg::beat_cnt_t'(MAX_BURST_LEN - 1);

	s2mm_pkg::split_state_e state;
	s2mm_pkg::beat_cnt_t    rmn_sub1;    // beats left in command, minus one
	logic [B4K_W-1:0]       rmn_4k_sub1; // beats left before the boundary, minus one
	s2mm_pkg::addr_t        addr_q;
	s2mm_pkg::axi_len_t     len_q;
	logic                   rmn_won;     // remaining count beat the max length
	logic                   last_q;
	logic [24:0]            cmd_end;
	s2mm_pkg::beat_cnt_t    cmd_beats;
	logic                   gen_le;
	logic                   clip_le;

	// only the unaligned part of the base address counts toward the beats
	assign cmd_end   = 25'(cmd_i.btt) + 25'(cmd_i.addr[OFS_W-1:0]);
	assign cmd_beats = s2mm_pkg::beat_cnt_t'(cmd_end[24:OFS_W]) +
		s2mm_pkg::beat_cnt_t'(|cmd_end[OFS_W-1:0]);

	assign gen_le  = rmn_sub1 <= MAX_LEN_SUB1;
	assign clip_le = 16'(len_q) <= 16'(rmn_4k_sub1);

	assign cmd_ready_o    = state == s2mm_pkg::IDLE;
	assign launch_valid_o = state == s2mm_pkg::LAUNCH;
	assign desc_o         = '{addr: addr_q, len: len_q, last_of_cmd: last_q};

	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn)
	begin
		if (!m_axi_aresetn)
			state <= s2mm_pkg::IDLE;
		else
		begin
			case (state)
				s2mm_pkg::IDLE:
					if (cmd_valid_i)
						state <= s2mm_pkg::GEN_LEN;
				s2mm_pkg::GEN_LEN:
					if (launch_ready_i) // hold until an entry is free
						state <= s2mm_pkg::CLIP_4K;
				s2mm_pkg::CLIP_4K:
					state <= s2mm_pkg::LAUNCH;
				default:
					if (launch_ready_i)
						state <= last_q ? s2mm_pkg::IDLE : s2mm_pkg::GEN_LEN;
			endcase
		end
	end

	always_ff @(posedge m_axi_aclk)
	begin
		case (state)
			s2mm_pkg::IDLE:
				if (cmd_valid_i)
				begin
					rmn_sub1    <= cmd_beats - 24'd1;
					rmn_4k_sub1 <= ~cmd_i.addr[11:OFS_W];
					addr_q      <= cmd_i.addr;
				end
			s2mm_pkg::GEN_LEN:
				if (launch_ready_i)
				begin
					len_q   <= s2mm_pkg::axi_len_t'(gen_le ? rmn_sub1 : MAX_LEN_SUB1);
					rmn_won <= gen_le;
				end
			s2mm_pkg::CLIP_4K:
			begin
				if (!clip_le)
					len_q <= s2mm_pkg::axi_len_t'(rmn_4k_sub1); // stop at the 4 KB edge
				last_q <= rmn_won & clip_le;
			end
			default:
				if (launch_ready_i)
				begin
					rmn_sub1    <= rmn_sub1 - (s2mm_pkg::beat_cnt_t'(len_q) + 24'd1);
					rmn_4k_sub1 <= rmn_4k_sub1 - (B4K_W'(len_q) + B4K_W'(1)); // wraps at edge
					// later bursts start aligned
					addr_q <= {addr_q[31:OFS_W], {OFS_W{1'b0}}} +
						((s2mm_pkg::addr_t'(len_q) + 32'd1) << OFS_W);
				end
		endcase
	end

endmodule

// ==== hw/s2mm_burst_table.sv ====
module s2mm_burst_table (
	input  logic                  m_axi_aclk,
	input  logic                  m_axi_aresetn,
	input  s2mm_pkg::burst_desc_t desc_i,
	input  logic                  launch_valid_i,
	output logic                  launch_ready_o,
	output s2mm_pkg::burst_desc_t prep_desc_o,
	output logic                  prep_valid_o,
	input  logic                  prep_done_i,
	output s2mm_pkg::addr_t       awaddr_o,
	output s2mm_pkg::axi_len_t    awlen_o,
	output logic                  awvalid_o,
	input  logic                  awready_i,
	input  logic [1:0]            bresp_i,
	input  logic                  bvalid_i,
	output logic                  err_resp_o
);

	localparam int PTR_W = $clog2(s2mm_pkg::TABLE_DEPTH);

	s2mm_pkg::entry_state_e ent_state [s2mm_pkg::TABLE_DEPTH];
	s2mm_pkg::burst_desc_t  ent_desc [s2mm_pkg::TABLE_DEPTH];

	logic [PTR_W-1:0] pl_ptr; // next entry to pre-launch
	logic [PTR_W-1:0] dp_ptr; // entry collecting data
	logic [PTR_W-1:0] tx_ptr; // entry waiting for AW
	logic [PTR_W-1:0] cp_ptr; // oldest entry waiting for B
	logic             do_launch;
	logic             do_prep;
	logic             do_issue;
	logic             do_cmplt;

	assign launch_ready_o = ent_state[pl_ptr] == s2mm_pkg::FREE;
	assign prep_valid_o   = ent_state[dp_ptr] == s2mm_pkg::PRE_LAUNCHED;
	assign prep_desc_o    = ent_desc[dp_ptr];
	assign awvalid_o      = ent_state[tx_ptr] == s2mm_pkg::DATA_READY;
	assign awaddr_o       = ent_desc[tx_ptr].addr;
	assign awlen_o        = ent_desc[tx_ptr].len;

	assign do_launch = launch_valid_i & launch_ready_o;
	assign do_prep   = prep_valid_o & prep_done_i;
	assign do_issue  = awvalid_o & awready_i;
	assign do_cmplt  = bvalid_i & (ent_state[cp_ptr] == s2mm_pkg::IN_TRANSFER); // B in order

	// each event needs a different entry state, so the pointers never collide
	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn)
	begin
		if (!m_axi_aresetn)
		begin
			for (int i = 0; i < s2mm_pkg::TABLE_DEPTH; i++)
				ent_state[i] <= s2mm_pkg::FREE;
			pl_ptr <= '0;
			dp_ptr <= '0;
			tx_ptr <= '0;
			cp_ptr <= '0;
		end
		else
		begin
			if (do_launch)
			begin
				ent_state[pl_ptr] <= s2mm_pkg::PRE_LAUNCHED;
				pl_ptr            <= pl_ptr + PTR_W'(1);
			end
			if (do_prep)
			begin
				ent_state[dp_ptr] <= s2mm_pkg::DATA_READY;
				dp_ptr            <= dp_ptr + PTR_W'(1);
			end
			if (do_issue)
			begin
				ent_state[tx_ptr] <= s2mm_pkg::IN_TRANSFER;
				tx_ptr            <= tx_ptr + PTR_W'(1);
			end
			if (do_cmplt)
			begin
				ent_state[cp_ptr] <= s2mm_pkg::FREE;
				cp_ptr            <= cp_ptr + PTR_W'(1);
			end
		end
	end

	always_ff @(posedge m_axi_aclk)
	begin
		if (do_launch)
			ent_desc[pl_ptr] <= desc_i;
	end

	// sticky on SLVERR or DECERR
	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn)
	begin
		if (!m_axi_aresetn)
			err_resp_o <= 1'b0;
		else if (bvalid_i & bresp_i[1])
			err_resp_o <= 1'b1;
	end

endmodule

// ==== hw/s2mm_beat_framer.sv ====
module s2mm_beat_framer #(
	parameter int DATA_WIDTH = 32
) (
	input  logic                    m_axi_aclk,
	input  logic                    m_axi_aresetn,
	input  logic [DATA_WIDTH-1:0]   s_data_i,
	input  logic [DATA_WIDTH/8-1:0] s_keep_i,
	input  logic                    s_last_i,
	input  logic                    s_valid_i,
	output logic                    s_ready_o,
	input  s2mm_pkg::burst_desc_t   prep_desc_i,
	input  logic                    prep_valid_i,
	output logic                    prep_done_o,
	output logic [DATA_WIDTH-1:0]   f_data_o,
	output logic [DATA_WIDTH/8-1:0] f_keep_o,
	output logic                    f_last_o,
	output logic                    f_valid_o,
	input  logic                    f_ready_i,
	output logic                    err_len_o
);

	s2mm_pkg::axi_len_t beat_cnt; // beats already passed in this burst
	logic               burst_last;
	logic               beat;

	assign burst_last = beat_cnt == prep_desc_i.len;

	// stream only moves while a burst is open for data
	assign f_valid_o = s_valid_i & prep_valid_i;
	assign s_ready_o = f_ready_i & prep_valid_i;
	assign f_data_o  = s_data_i;
	assign f_keep_o  = s_keep_i;
	assign f_last_o  = burst_last;

	assign beat        = s_valid_i & s_ready_o;
	assign prep_done_o = beat & burst_last;

	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn)
	begin
		if (!m_axi_aresetn)
			beat_cnt <= '0;
		else if (beat)
			beat_cnt <= burst_last ? '0 : beat_cnt + 8'd1;
	end

	// stream last must line up with the final beat of the command
	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn)
	begin
		if (!m_axi_aresetn)
			err_len_o <= 1'b0;
		else if (beat & !err_len_o)
			err_len_o <= s_last_i ^ (burst_last & prep_desc_i.last_of_cmd);
	end

endmodule

// ==== hw/s2mm_wdata_fifo.sv ====
module s2mm_wdata_fifo #(
	parameter int DATA_WIDTH = 32,
	parameter int DEPTH      = 32
) (
	input  logic                    m_axi_aclk,
	input  logic                    m_axi_aresetn,
	input  logic [DATA_WIDTH-1:0]   in_data_i,
	input  logic [DATA_WIDTH/8-1:0] in_keep_i,
	input  logic                    in_last_i,
	input  logic                    in_valid_i,
	output logic                    in_ready_o,
	output logic [DATA_WIDTH-1:0]   out_data_o,
	output logic [DATA_WIDTH/8-1:0] out_keep_o,
	output logic                    out_last_o,
	output logic                    out_valid_o,
	input  logic                    out_ready_i
);

	localparam int AW = $clog2(DEPTH);

	typedef struct packed {
		logic [DATA_WIDTH-1:0]   data;
		logic [DATA_WIDTH/8-1:0] keep;
		logic                    last;
	} beat_t;

	beat_t       mem [DEPTH];
	beat_t       in_beat;
	beat_t       out_q;
	logic [AW:0] wr_ptr; // extra bit tells full from empty
	logic [AW:0] rd_ptr;
	logic        mem_empty;
	logic        push;
	logic        out_load;
	logic        bypass;

	assign in_beat    = '{data: in_data_i, keep: in_keep_i, last: in_last_i};
	assign mem_empty  = wr_ptr == rd_ptr;
	assign in_ready_o = (wr_ptr ^ rd_ptr) != {1'b1, {AW{1'b0}}};
	assign push       = in_valid_i & in_ready_o;
	assign out_load   = !out_valid_o | out_ready_i;
	assign bypass     = out_load & mem_empty & push; // straight into the output stage

	assign out_data_o = out_q.data;
	assign out_keep_o = out_q.keep;
	assign out_last_o = out_q.last;

	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn)
	begin
		if (!m_axi_aresetn)
		begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			out_valid_o <= 1'b0;
		end
		else
		begin
			if (push & !bypass)
				wr_ptr <= wr_ptr + (AW+1)'(1);
			if (out_load & !mem_empty)
				rd_ptr <= rd_ptr + (AW+1)'(1);
			if (out_load)
				out_valid_o <= !mem_empty | push;
		end
	end

	always_ff @(posedge m_axi_aclk)
	begin
		if (push & !bypass)
			mem[wr_ptr[AW-1:0]] <= in_beat;
		if (out_load)
			out_q <= mem_empty ? in_beat : mem[rd_ptr[AW-1:0]];
	end

endmodule

// ==== hw/s2mm_dma_top.sv ====
module s2mm_dma_top #(
	parameter int DATA_WIDTH    = 32,
	parameter int MAX_BURST_LEN = 16
) (
	input  logic                    m_axi_aclk,
	input  logic                    m_axi_aresetn,
	input  s2mm_pkg::cmd_t          cmd_i,
	input  logic                    cmd_valid_i,
	output logic                    cmd_ready_o,
	input  logic [DATA_WIDTH-1:0]   s_data_i,
	input  logic [DATA_WIDTH/8-1:0] s_keep_i,
	input  logic                    s_last_i,
	input  logic                    s_valid_i,
	output logic                    s_ready_o,
	output s2mm_pkg::addr_t         m_axi_awaddr_o,
	output s2mm_pkg::axi_len_t      m_axi_awlen_o,
	output logic [2:0]              m_axi_awsize_o,
	output logic [1:0]              m_axi_awburst_o,
	output logic [3:0]              m_axi_awcache_o,
	output logic [2:0]              m_axi_awprot_o,
	output logic                    m_axi_awvalid_o,
	input  logic                    m_axi_awready_i,
	output logic [DATA_WIDTH-1:0]   m_axi_wdata_o,
	output logic [DATA_WIDTH/8-1:0] m_axi_wstrb_o,
	output logic                    m_axi_wlast_o,
	output logic                    m_axi_wvalid_o,
	input  logic                    m_axi_wready_i,
	input  logic [1:0]              m_axi_bresp_i,
	input  logic                    m_axi_bvalid_i,
	output logic                    m_axi_bready_o,
	output logic                    err_resp_o,
	output logic                    err_len_o
);

	s2mm_pkg::burst_desc_t   launch_desc;
	logic                    launch_valid;
	logic                    launch_ready;
	s2mm_pkg::burst_desc_t   prep_desc;
	logic                    prep_valid;
	logic                    prep_done;
	logic [DATA_WIDTH-1:0]   f_data;
	logic [DATA_WIDTH/8-1:0] f_keep;
	logic                    f_last;
	logic                    f_valid;
	logic                    f_ready;

	assign m_axi_awsize_o  = 3'($clog2(DATA_WIDTH / 8)); // full-width beats
	assign m_axi_awburst_o = s2mm_pkg::AXI_BURST_INCR;
	assign m_axi_awcache_o = s2mm_pkg::AXI_CACHE_DEFAULT;
	assign m_axi_awprot_o  = s2mm_pkg::AXI_PROT_DEFAULT;
	assign m_axi_bready_o  = 1'b1;

	s2mm_burst_splitter #(
		.DATA_WIDTH   (DATA_WIDTH),
		.MAX_BURST_LEN(MAX_BURST_LEN)
	) i_splitter (
		.m_axi_aclk    (m_axi_aclk),
		.m_axi_aresetn (m_axi_aresetn),
		.cmd_i         (cmd_i),
		.cmd_valid_i   (cmd_valid_i),
		.cmd_ready_o   (cmd_ready_o),
		.desc_o        (launch_desc),
		.launch_valid_o(launch_valid),
		.launch_ready_i(launch_ready)
	);

	s2mm_burst_table i_table (
		.m_axi_aclk    (m_axi_aclk),
		.m_axi_aresetn (m_axi_aresetn),
		.desc_i        (launch_desc),
		.launch_valid_i(launch_valid),
		.launch_ready_o(launch_ready),
		.prep_desc_o   (prep_desc),
		.prep_valid_o  (prep_valid),
		.prep_done_i   (prep_done),
		.awaddr_o      (m_axi_awaddr_o),
		.awlen_o       (m_axi_awlen_o),
		.awvalid_o     (m_axi_awvalid_o),
		.awready_i     (m_axi_awready_i),
		.bresp_i       (m_axi_bresp_i),
		.bvalid_i      (m_axi_bvalid_i),
		.err_resp_o    (err_resp_o)
	);

	s2mm_beat_framer #(
		.DATA_WIDTH(DATA_WIDTH)
	) i_framer (
		.m_axi_aclk   (m_axi_aclk),
		.m_axi_aresetn(m_axi_aresetn),
		.s_data_i     (s_data_i),
		.s_keep_i     (s_keep_i),
		.s_last_i     (s_last_i),
		.s_valid_i    (s_valid_i),
		.s_ready_o    (s_ready_o),
		.prep_desc_i  (prep_desc),
		.prep_valid_i (prep_valid),
		.prep_done_o  (prep_done),
		.f_data_o     (f_data),
		.f_keep_o     (f_keep),
		.f_last_o     (f_last),
		.f_valid_o    (f_valid),
		.f_ready_i    (f_ready),
		.err_len_o    (err_len_o)
	);

	// room for two full bursts
	s2mm_wdata_fifo #(
		.DATA_WIDTH(DATA_WIDTH),
		.DEPTH     (2 * MAX_BURST_LEN)
	) i_wdata_fifo (
		.m_axi_aclk   (m_axi_aclk),
		.m_axi_aresetn(m_axi_aresetn),
		.in_data_i    (f_data),
		.in_keep_i    (f_keep),
		.in_last_i    (f_last),
		.in_valid_i   (f_valid),
		.in_ready_o   (f_ready),
		.out_data_o   (m_axi_wdata_o),
		.out_keep_o   (m_axi_wstrb_o),
		.out_last_o   (m_axi_wlast_o),
		.out_valid_o  (m_axi_wvalid_o),
		.out_ready_i  (m_axi_wready_i)
	);

endmodule

// ==== test/s2mm_sva.sv ====
module s2mm_sva (
	input logic        m_axi_aclk,
	input logic        m_axi_aresetn,
	input logic        cmd_ready_i,
	input logic        s_ready_i,
	input logic [31:0] awaddr_i,
	input logic [7:0]  awlen_i,
	input logic        awvalid_i,
	input logic        awready_i,
	input logic [31:0] wdata_i,
	input logic [3:0]  wstrb_i,
	input logic        wlast_i,
	input logic        wvalid_i,
	input logic        wready_i
);

	int fail_cnt = 0; // failed assertion count

	property aw_hold;
		@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
		awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i) && $stable(awlen_i);
	endproperty

	property w_hold;
		@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
		wvalid_i && !wready_i |=> wvalid_i && $stable({wdata_i, wstrb_i, wlast_i});
	endproperty

	a_aw_hold: assert property (aw_hold)
		else
		begin
			$error("AW payload moved while stalled");
			fail_cnt++;
		end
	a_w_hold: assert property (w_hold)
		else
		begin
			$error("W payload moved while stalled");
			fail_cnt++;
		end

	a_known: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
		!$isunknown({awvalid_i, wvalid_i, s_ready_i, cmd_ready_i}))
		else
		begin
			$error("handshake signal unknown");
			fail_cnt++;
		end

endmodule

bind s2mm_dma_top s2mm_sva i_sva (
	.m_axi_aclk   (m_axi_aclk),
	.m_axi_aresetn(m_axi_aresetn),
	.cmd_ready_i  (cmd_ready_o),
	.s_ready_i    (s_ready_o),
	.awaddr_i     (m_axi_awaddr_o),
	.awlen_i      (m_axi_awlen_o),
	.awvalid_i    (m_axi_awvalid_o),
	.awready_i    (m_axi_awready_i),
	.wdata_i      (m_axi_wdata_o),
	.wstrb_i      (m_axi_wstrb_o),
	.wlast_i      (m_axi_wlast_o),
	.wvalid_i     (m_axi_wvalid_o),
	.wready_i     (m_axi_wready_i)
);

// ==== test/s2mm_checker.sv ====
module s2mm_checker (
	input logic                    m_axi_aclk,
	input logic                    m_axi_aresetn,
	input logic                    cmd_ready_i,
	input logic                    s_valid_i,
	input logic                    s_ready_i,
	input s2mm_pkg::addr_t         awaddr_i,
	input s2mm_pkg::axi_len_t      awlen_i,
	input logic [2:0]              awsize_i,
	input logic [1:0]              awburst_i,
	input logic [3:0]              awcache_i,
	input logic [2:0]              awprot_i,
	input logic                    awvalid_i,
	input logic                    awready_i,
	input logic [31:0]             wdata_i,
	input logic [3:0]              wstrb_i,
	input logic                    wlast_i,
	input logic                    wvalid_i,
	input logic                    wready_i,
	input logic [1:0]              bresp_i,
	input logic                    bvalid_i,
	input logic                    bready_i,
	input logic                    err_resp_i,
	input logic                    err_len_i
);

	logic [31:0]        trace [0:63];
	s2mm_pkg::addr_t    exp_addr [0:63];
	s2mm_pkg::axi_len_t exp_len [0:63];
	int                 n_exp = 0;
	int                 total_good = 0; // beats of the commands that are not short
	int                 aw_idx = 0;
	int                 w_idx = 0;
	int                 w_beat = 0;
	int                 w_cnt = 0;
	int                 s_cnt = 0;
	int                 err_cnt = 0;
	logic               seen_err = 1'b0;
	logic               all_seen;

	assign all_seen = (aw_idx == n_exp) && (w_cnt == total_good);

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		$display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
		err_cnt++;
	endtask

	task automatic report_failure(input string msg);
		$display("error at %0t: %s", $time, msg);
		err_cnt++;
	endtask

	// cut one command into bursts: 16 beats max, never across 4 KB
	task automatic predict_bursts(input logic [31:0] addr, input logic [31:0] btt);
		int          beats;
		int          len;
		int          to_edge;
		logic [31:0] a;
		beats = int'((btt + 32'(addr[1:0]) + 32'd3) >> 2);
		total_good += beats;
		a = addr;
		while (beats > 0)
		begin
			to_edge = 1024 - int'(a[11:2]);
			len = beats;
			if (len > 16)
				len = 16;
			if (len > to_edge)
				len = to_edge;
			exp_addr[n_exp] = a;
			exp_len[n_exp] = 8'(len - 1);
			n_exp++;
			beats -= len;
			a = {a[31:2], 2'b00} + 32'(len * 4);
		end
	endtask

	initial
	begin
		for (int i = 0; i < 64; i++)
			trace[i] = {16'hfeed, 16'(i)}; // marks words the trace leaves unset
		$readmemh("test/s2mm_trace.txt", trace);
		for (int i = 0; i < 16 && trace[4*i] != {16'hfeed, 16'(4*i)}; i++)
			if (!trace[4*i+3][0])
				predict_bursts(trace[4*i], trace[4*i+1]);
	end

	always @(negedge m_axi_aclk)
	begin
		if (bready_i !== 1'b1)
			report_mismatch("m_axi_bready_o", 32'd1, 32'(bready_i));
		if (!m_axi_aresetn)
		begin
			if (cmd_ready_i !== 1'b1)
				report_mismatch("cmd_ready_o", 32'd1, 32'(cmd_ready_i));
			if (awvalid_i !== 1'b0)
				report_mismatch("m_axi_awvalid_o", 32'd0, 32'(awvalid_i));
			if (wvalid_i !== 1'b0)
				report_mismatch("m_axi_wvalid_o", 32'd0, 32'(wvalid_i));
			if (s_ready_i !== 1'b0)
				report_mismatch("s_ready_o", 32'd0, 32'(s_ready_i));
			if (err_resp_i !== 1'b0)
				report_mismatch("err_resp_o", 32'd0, 32'(err_resp_i));
			if (err_len_i !== 1'b0)
				report_mismatch("err_len_o", 32'd0, 32'(err_len_i));
		end
		else
		begin
			if (awvalid_i && awready_i)
			begin
				if (aw_idx >= n_exp)
					report_failure("burst issued that no command asked for");
				else
				begin
					if (awaddr_i != exp_addr[aw_idx])
						report_mismatch("m_axi_awaddr_o", exp_addr[aw_idx], awaddr_i);
					if (awlen_i != exp_len[aw_idx])
						report_mismatch("m_axi_awlen_o", 32'(exp_len[aw_idx]), 32'(awlen_i));
				end
				if (awlen_i > 8'd15)
					report_failure("burst longer than 16 beats");
				if (32'(awaddr_i[11:2]) + 32'(awlen_i) > 32'd1023)
					report_failure("burst crosses a 4 KB boundary");
				if (awsize_i != 3'd2)
					report_mismatch("m_axi_awsize_o", 32'd2, 32'(awsize_i));
				if (awburst_i != 2'b01)
					report_mismatch("m_axi_awburst_o", 32'd1, 32'(awburst_i));
				if (awcache_i != 4'b0011)
					report_mismatch("m_axi_awcache_o", 32'h3, 32'(awcache_i));
				if (awprot_i != 3'b000)
					report_mismatch("m_axi_awprot_o", 32'd0, 32'(awprot_i));
				aw_idx++;
			end
			// beats past the good ones belong to the short command
			if (wvalid_i && wready_i && w_cnt < total_good)
			begin
				if (wdata_i != 32'(w_cnt))
					report_mismatch("m_axi_wdata_o", 32'(w_cnt), wdata_i);
				if (wstrb_i != 4'hf)
					report_mismatch("m_axi_wstrb_o", 32'hf, 32'(wstrb_i));
				if (wlast_i != (w_beat == int'(exp_len[w_idx])))
					report_mismatch("m_axi_wlast_o", 32'(w_beat == int'(exp_len[w_idx])),
						32'(wlast_i));
				if (w_beat == int'(exp_len[w_idx]))
				begin
					w_beat = 0;
					w_idx++;
				end
				else
					w_beat++;
				w_cnt++;
			end
			if (err_resp_i != seen_err)
				report_mismatch("err_resp_o", 32'(seen_err), 32'(err_resp_i));
			if (bvalid_i && bresp_i[1])
				seen_err = 1'b1; // bready is tied high
			if (err_len_i && s_cnt <= total_good)
				report_failure("err_len_o rose before the short stream");
			if (s_valid_i && s_ready_i)
				s_cnt++;
		end
	end

endmodule

// ==== test/tb_s2mm.sv ====
module tb_s2mm;

	localparam int DATA_WIDTH    = 32;
	localparam int MAX_BURST_LEN = 16;
	localparam int MAX_CMDS      = 16;

	logic                  m_axi_aclk = 1'b0;
	logic                  m_axi_aresetn;
	s2mm_pkg::cmd_t        cmd;
	logic                  cmd_valid;
	logic                  cmd_ready;
	logic [31:0]           s_data;
	logic [3:0]            s_keep;
	logic                  s_last;
	logic                  s_valid;
	logic                  s_ready;
	s2mm_pkg::addr_t       awaddr;
	s2mm_pkg::axi_len_t    awlen;
	logic [2:0]            awsize;
	logic [1:0]            awburst;
	logic [3:0]            awcache;
	logic [2:0]            awprot;
	logic                  awvalid;
	logic                  awready;
	logic [31:0]           wdata;
	logic [3:0]            wstrb;
	logic                  wlast;
	logic                  wvalid;
	logic                  wready;
	logic [1:0]            bresp;
	logic                  bvalid;
	logic                  bready;
	logic                  err_resp;
	logic                  err_len;

	logic [31:0] trace [0:4*MAX_CMDS-1];
	logic [1:0]  resp_arr [0:63]; // response code per accepted burst
	int          n_cmds = 0;
	int          seed = 98;
	int          aw_cnt = 0;
	int          wlast_cnt = 0;
	int          b_cnt = 0;
	int          tb_err = 0;

	always #4 m_axi_aclk = ~m_axi_aclk;

	s2mm_dma_top #(
		.DATA_WIDTH   (DATA_WIDTH),
		.MAX_BURST_LEN(MAX_BURST_LEN)
	) i_dut (
		.m_axi_aclk(m_axi_aclk), .m_axi_aresetn(m_axi_aresetn),
		.cmd_i(cmd), .cmd_valid_i(cmd_valid), .cmd_ready_o(cmd_ready),
		.s_data_i(s_data), .s_keep_i(s_keep), .s_last_i(s_last),
		.s_valid_i(s_valid), .s_ready_o(s_ready),
		.m_axi_awaddr_o(awaddr), .m_axi_awlen_o(awlen), .m_axi_awsize_o(awsize),
		.m_axi_awburst_o(awburst), .m_axi_awcache_o(awcache), .m_axi_awprot_o(awprot),
		.m_axi_awvalid_o(awvalid), .m_axi_awready_i(awready),
		.m_axi_wdata_o(wdata), .m_axi_wstrb_o(wstrb), .m_axi_wlast_o(wlast),
		.m_axi_wvalid_o(wvalid), .m_axi_wready_i(wready),
		.m_axi_bresp_i(bresp), .m_axi_bvalid_i(bvalid), .m_axi_bready_o(bready),
		.err_resp_o(err_resp), .err_len_o(err_len)
	);

	s2mm_checker i_chk (
		.m_axi_aclk(m_axi_aclk), .m_axi_aresetn(m_axi_aresetn),
		.cmd_ready_i(cmd_ready), .s_valid_i(s_valid), .s_ready_i(s_ready),
		.awaddr_i(awaddr), .awlen_i(awlen), .awsize_i(awsize), .awburst_i(awburst),
		.awcache_i(awcache), .awprot_i(awprot),
		.awvalid_i(awvalid), .awready_i(awready),
		.wdata_i(wdata), .wstrb_i(wstrb), .wlast_i(wlast),
		.wvalid_i(wvalid), .wready_i(wready),
		.bresp_i(bresp), .bvalid_i(bvalid), .bready_i(bready),
		.err_resp_i(err_resp), .err_len_i(err_len)
	);

	// bresp comes from the command whose byte range holds the burst
	function automatic logic [1:0] lookup_resp(input logic [31:0] addr);
		for (int i = 0; i < n_cmds; i++)
			if (addr >= trace[4*i] && addr < trace[4*i] + trace[4*i+1])
				return trace[4*i+2][1:0];
		return 2'b00;
	endfunction

	function automatic int stream_beats(input int idx);
		int beats;
		beats = int'((trace[4*idx+1] + 32'(trace[4*idx][1:0]) + 32'd3) >> 2);
		if (trace[4*idx+3][0])
			beats--; // last marker one beat early
		return beats;
	endfunction

	task automatic drive_commands();
		for (int i = 0; i < n_cmds; i++)
		begin
			cmd       <= '{addr: trace[4*i], btt: trace[4*i+1][23:0]};
			cmd_valid <= 1'b1;
			@(posedge m_axi_aclk);
			while (!cmd_ready)
				@(posedge m_axi_aclk);
		end
		cmd_valid <= 1'b0;
	endtask

	task automatic drive_stream();
		int n;
		int beats;
		n = 0;
		for (int i = 0; i < n_cmds; i++)
		begin
			beats = stream_beats(i);
			for (int b = 0; b < beats; b++)
			begin
				s_data  <= 32'(n);
				s_keep  <= 4'hf;
				s_last  <= (b == beats - 1);
				s_valid <= 1'b1;
				@(posedge m_axi_aclk);
				while (!s_ready)
					@(posedge m_axi_aclk);
				n++;
			end
		end
		s_valid <= 1'b0;
	endtask

	// AXI slave with random ready, one B per burst once AW and W are both done
	always @(posedge m_axi_aclk)
	begin
		if (m_axi_aresetn)
		begin
			awready <= 1'($random(seed));
			wready  <= 1'($random(seed));
			if (awvalid && awready)
			begin
				resp_arr[aw_cnt] = lookup_resp(awaddr);
				aw_cnt++;
			end
			if (wvalid && wready && wlast)
				wlast_cnt++;
			if (b_cnt < aw_cnt && b_cnt < wlast_cnt)
			begin
				bvalid <= 1'b1;
				bresp  <= resp_arr[b_cnt];
				b_cnt++;
			end
			else
				bvalid <= 1'b0;
		end
	end

	initial
	begin
		m_axi_aresetn = 1'b0;
		cmd           = '0;
		cmd_valid     = 1'b0;
		s_data        = '0;
		s_keep        = '0;
		s_last        = 1'b0;
		s_valid       = 1'b0;
		awready       = 1'b0;
		wready        = 1'b0;
		bresp         = 2'b00;
		bvalid        = 1'b0;
		for (int i = 0; i < 4 * MAX_CMDS; i++)
			trace[i] = {16'hfeed, 16'(i)}; // marks words the trace leaves unset
		$readmemh("test/s2mm_trace.txt", trace);
		while (n_cmds < MAX_CMDS && trace[4*n_cmds] != {16'hfeed, 16'(4*n_cmds)})
			n_cmds++;
		repeat (10) @(posedge m_axi_aclk);
		m_axi_aresetn <= 1'b1;
		fork
			drive_commands();
			drive_stream();
		join
		while (!(i_chk.all_seen && err_len && !bvalid && b_cnt == aw_cnt))
			@(posedge m_axi_aclk);
		repeat (4) @(posedge m_axi_aclk);
		if (!err_resp)
		begin
			$display("mismatch at %0t: err_resp_o expected 1 got 0", $time);
			tb_err++;
		end
		$display("errors: checker %0d, assertions %0d, testbench %0d",
			i_chk.err_cnt, i_dut.i_sva.fail_cnt, tb_err);
		if (i_chk.err_cnt == 0 && i_dut.i_sva.fail_cnt == 0 && tb_err == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// run length scales with the trace
	initial
	begin
		repeat (10) @(posedge m_axi_aclk);
		repeat (200 * n_cmds + 1000) @(posedge m_axi_aclk);
		$display("timeout: transfers did not complete in %0d cycles", 200 * n_cmds + 1000);
		$display("errors: checker %0d, assertions %0d, testbench %0d",
			i_chk.err_cnt, i_dut.i_sva.fail_cnt, tb_err);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== filelist.f ====
hw/s2mm_pkg.sv
hw/s2mm_burst_splitter.sv
hw/s2mm_burst_table.sv
hw/s2mm_beat_framer.sv
hw/s2mm_wdata_fifo.sv
hw/s2mm_dma_top.sv
test/s2mm_sva.sv
test/s2mm_checker.sv
test/tb_s2mm.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the s2mm testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_s2mm -o sim_tb_s2mm
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

output=$(./obj_dir/sim_tb_s2mm)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1

// ==== test/s2mm_trace.txt ====
// columns: base address, byte count, bresp to return, short-stream flag
// the short command must stay on the last line
00001000 00000040 0 0
00001ff2 00000030 0 0
00002100 000000b0 0 0
00003000 00000024 2 0
00003100 0000001c 0 0
00004000 00000008 0 1
